// File: flist.f
rtl/rvPkg.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/aluPipe.sv
tb/aluPipe_asserts.sv
tb/aluPipeTb.sv

// File: rtl/aluPipe.sv
module aluPipe (
  input  logic clk,
  input  logic reset,
  input  logic instrValid,
  input  rvPkg::instrU instr,
  input  logic [rvPkg::regAddrWidth-1:0] dbgAddr,
  output rvPkg::wbT retire,
  output logic [rvPkg::xlen-1:0] dbgData
);
  import rvPkg::*;

  logic [regAddrWidth-1:0] rs1;
  logic [regAddrWidth-1:0] rs2;
  logic [xlen-1:0] rs1Data;
  logic [xlen-1:0] rs2Data;
  decodedOpT dec;
  wbT wb;

  decodeStage decodeStage_inst (
    .clk(clk),
    .reset(reset),
    .instrValid(instrValid),
    .instr(instr),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .wb(wb),
    .rs1(rs1),
    .rs2(rs2),
    .dec(dec)
  );

  executeStage executeStage_inst (
    .clk(clk),
    .reset(reset),
    .dec(dec),
    .wb(wb)
  );

  // Write-back also feeds the decode bypass and the retire port
  registerFile registerFile_inst (
    .clk(clk),
    .wb(wb),
    .rs1(rs1),
    .rs2(rs2),
    .dbgAddr(dbgAddr),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .dbgData(dbgData)
  );

  assign retire = wb;

endmodule

// File: rtl/decodeStage.sv
module decodeStage (
  input  logic clk,
  input  logic reset,
  input  logic instrValid,
  input  rvPkg::instrU instr,
  input  logic [rvPkg::xlen-1:0] rs1Data,
  input  logic [rvPkg::xlen-1:0] rs2Data,
  input  rvPkg::wbT wb,
  output logic [rvPkg::regAddrWidth-1:0] rs1,
  output logic [rvPkg::regAddrWidth-1:0] rs2,
  output rvPkg::decodedOpT dec
);
  import rvPkg::*;

  instrU instrQ;
  logic instrValidQ;
  aluOpE aluOp;
  logic illegal;
  logic useImm;
  logic [regAddrWidth-1:0] srcA;
  logic [regAddrWidth-1:0] srcB;
  logic [regAddrWidth-1:0] destReg;
  logic [xlen-1:0] imm;
  logic [6:0] shiftFunct;
  logic wbFwd;
  logic [xlen-1:0] opAValue;
  logic [xlen-1:0] opBValue;

  function automatic aluOpE aluFromFunct3(input logic [2:0] funct3, input logic alt);
    aluOpE op;
    case (funct3)
      f3AddSub: op = alt ? aluSub : aluAdd;
      f3Sll:    op = aluSll;
      f3Slt:    op = aluSlt;
      f3Sltu:   op = aluSltu;
      f3Xor:    op = aluXor;
      f3SrlSra: op = alt ? aluSra : aluSrl;
      f3Or:     op = aluOr;
      default:  op = aluAnd;
    endcase
    return op;
  endfunction

  // Issue slot register, operands are read in the following cycle
  always_ff @(posedge clk) begin
    instrQ <= instr;
    instrValidQ <= instrValid;
    if (reset) begin
      instrValidQ <= 1'b0;
    end
  end

  assign shiftFunct = instrQ.iType.imm12[11:5]; // Upper immediate bits act as funct7 on shifts

  always_comb begin
    aluOp = aluAdd;
    illegal = 1'b0;
    useImm = 1'b0;
    srcA = instrQ.rType.rs1;
    srcB = instrQ.rType.rs2;
    destReg = instrQ.rType.rd;
    imm = {{(xlen - 12){instrQ.iType.imm12[11]}}, instrQ.iType.imm12};
    case (instrQ.rType.opcode)
      opOp: begin
        aluOp = aluFromFunct3(instrQ.rType.funct3, instrQ.rType.funct7 == f7Alt);
        if (instrQ.rType.funct7 == f7Alt) begin
          illegal = !(instrQ.rType.funct3 == f3AddSub || instrQ.rType.funct3 == f3SrlSra);
        end else if (instrQ.rType.funct7 != f7Base) begin
          illegal = 1'b1;
        end
      end
      opOpImm: begin
        useImm = 1'b1;
        srcB = '0;
        aluOp = aluFromFunct3(instrQ.iType.funct3,
                              instrQ.iType.funct3 == f3SrlSra && shiftFunct == f7Alt);
        if (instrQ.iType.funct3 == f3Sll) begin
          illegal = (shiftFunct != f7Base);
        end else if (instrQ.iType.funct3 == f3SrlSra) begin
          illegal = (shiftFunct != f7Base) && (shiftFunct != f7Alt);
        end
      end
      opLui: begin
        useImm = 1'b1;
        aluOp = aluPassB;
        srcA = '0; // These bits belong to the immediate here
        srcB = '0;
        imm = {instrQ[31:12], 12'b0};
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  assign rs1 = srcA;
  assign rs2 = srcB;

  // Covers the instruction two ahead, which is retiring right now
  assign wbFwd = wbWrites(wb);
  assign opAValue = (wbFwd && wb.rd == srcA) ? wb.data : rs1Data;
  assign opBValue = useImm ? imm : ((wbFwd && wb.rd == srcB) ? wb.data : rs2Data);

  always_ff @(posedge clk) begin
    dec.valid <= instrValidQ;
    dec.illegal <= instrValidQ && illegal;
    dec.aluOp <= aluOp;
    dec.rd <= destReg;
    dec.rs1 <= srcA;
    dec.rs2 <= srcB;
    dec.useImm <= useImm;
    dec.opA <= opAValue;
    dec.opB <= opBValue;
    if (reset) begin
      dec.valid <= 1'b0;
    end
  end

endmodule

// File: rtl/executeStage.sv
module executeStage (
  input  logic clk,
  input  logic reset,
  input  rvPkg::decodedOpT dec,
  output rvPkg::wbT wb
);
  import rvPkg::*;

  logic ownFwd;
  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [shamtWidth-1:0] shamt;
  logic [xlen-1:0] result;

  // Result of the previous instruction has not reached the register file yet
  assign ownFwd = wbWrites(wb);
  assign a = (ownFwd && wb.rd == dec.rs1) ? wb.data : dec.opA;
  assign b = (!dec.useImm && ownFwd && wb.rd == dec.rs2) ? wb.data : dec.opB;

  assign shamt = b[shamtWidth-1:0];

  always_comb begin
    case (dec.aluOp)
      aluAdd: begin
        result = a + b;
      end
      aluSub: begin
        result = a - b;
      end
      aluSll: begin
        result = a << shamt;
      end
      aluSlt: begin
        result = {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
      end
      aluSltu: begin
        result = {{(xlen - 1){1'b0}}, a < b};
      end
      aluXor: begin
        result = a ^ b;
      end
      aluSrl: begin
        result = a >> shamt;
      end
      aluSra: begin
        result = $signed(a) >>> shamt; // Fills with the sign bit
      end
      aluOr: begin
        result = a | b;
      end
      aluAnd: begin
        result = a & b;
      end
      aluPassB: begin
        result = b; // LUI
      end
      default: begin
        result = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    wb.valid <= dec.valid;
    wb.illegal <= dec.illegal;
    wb.rd <= dec.rd;
    wb.data <= dec.illegal ? '0 : result;
    if (reset) begin
      wb.valid <= 1'b0;
    end
  end

endmodule

// File: rtl/registerFile.sv
module registerFile (
  input  logic clk,
  input  rvPkg::wbT wb,
  input  logic [rvPkg::regAddrWidth-1:0] rs1,
  input  logic [rvPkg::regAddrWidth-1:0] rs2,
  input  logic [rvPkg::regAddrWidth-1:0] dbgAddr,
  output logic [rvPkg::xlen-1:0] rs1Data,
  output logic [rvPkg::xlen-1:0] rs2Data,
  output logic [rvPkg::xlen-1:0] dbgData
);
  import rvPkg::*;

  logic [xlen-1:0] regs [numRegs];
  logic writeEn;

  assign writeEn = wbWrites(wb); // Entry 0 is never written

  always_ff @(posedge clk) begin
    if (writeEn) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // x0 reads as zero on every port, whatever the storage holds
  assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];
  assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

// File: rtl/rvPkg.sv
package rvPkg;

  localparam int xlen = 32;
  localparam int regAddrWidth = 5;
  localparam int numRegs = 2 ** regAddrWidth;
  localparam int shamtWidth = 5;

  localparam logic [6:0] opOp = 7'b0110011;
  localparam logic [6:0] opOpImm = 7'b0010011;
  localparam logic [6:0] opLui = 7'b0110111;

  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll = 3'b001;
  localparam logic [2:0] f3Slt = 3'b010;
  localparam logic [2:0] f3Sltu = 3'b011;
  localparam logic [2:0] f3Xor = 3'b100;
  localparam logic [2:0] f3SrlSra = 3'b101;
  localparam logic [2:0] f3Or = 3'b110;
  localparam logic [2:0] f3And = 3'b111;

  localparam logic [6:0] f7Base = 7'b0000000;
  localparam logic [6:0] f7Alt = 7'b0100000; // Selects SUB and SRA

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB
  } aluOpE;

  typedef struct packed {
    logic [6:0] funct7;
    logic [regAddrWidth-1:0] rs2;
    logic [regAddrWidth-1:0] rs1;
    logic [2:0] funct3;
    logic [regAddrWidth-1:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm12;
    logic [regAddrWidth-1:0] rs1;
    logic [2:0] funct3;
    logic [regAddrWidth-1:0] rd;
    logic [6:0] opcode;
  } iTypeT;

  typedef union packed {
    rTypeT rType;
    iTypeT iType;
  } instrU;

  typedef struct packed {
    logic valid;
    logic illegal;
    aluOpE aluOp;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic useImm;
    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB; // Holds the immediate when useImm is set
  } decodedOpT;

  typedef struct packed {
    logic valid;
    logic illegal;
    logic [regAddrWidth-1:0] rd;
    logic [xlen-1:0] data;
  } wbT;

  // A write-back that really lands in the register file
  function automatic logic wbWrites(input wbT w);
    return w.valid && !w.illegal && (w.rd != '0);
  endfunction

endpackage

// File: tb/aluPipeTb.sv
module aluPipeTb;
  import rvPkg::*;

  typedef struct packed {
    wbT wb;
    logic [31:0] cycle;
  } expectT;

  localparam int streamLen = 100;
  localparam int numInstrs = 31 + 8 + 21 + 10 + 3 + 4 + streamLen;
  localparam int idleCycles = 8 * 4; // Spacing in testImmediates
  localparam int dbgCycles = 6 * 32; // One cycle per register in each sweep
  localparam int drainCycles = 7 * 4;
  localparam int cycleLimit = 4 + numInstrs + idleCycles + dbgCycles + drainCycles + 50;

  logic clk;
  logic reset;
  logic instrValid;
  instrU instr;
  logic [regAddrWidth-1:0] dbgAddr;
  wbT retire;
  logic [xlen-1:0] dbgData;

  logic [31:0] shadow [32];
  expectT expQ [$];
  int cycles = 0;

  aluPipe aluPipe_inst (
    .clk(clk),
    .reset(reset),
    .instrValid(instrValid),
    .instr(instr),
    .dbgAddr(dbgAddr),
    .retire(retire),
    .dbgData(dbgData)
  );

  bind aluPipe aluPipeAsserts aluPipeAsserts_inst (
    .clk(clk),
    .reset(reset),
    .instrValid(instrValid),
    .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic reportFailure(input string what);
    $display("ERROR: %s", what);
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "run stopped at the first error");
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycleLimit) begin
      reportFailure($sformatf("timeout, tests did not finish within %0d cycles", cycleLimit));
    end
  end

  function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, opOp};
  endfunction

  function automatic logic [31:0] iTypeWord(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, f3, rd, opOpImm};
  endfunction

  function automatic logic [31:0] luiWord(input logic [4:0] rd, input logic [19:0] upper);
    return {upper, rd, opLui};
  endfunction

  // ISA semantics on the shadow registers, in program order
  task automatic applyModel(input logic [31:0] word, output wbT res);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    logic bad;
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] rd;
    f7 = word[31:25];
    f3 = word[14:12];
    rd = word[11:7];
    a = shadow[word[19:15]];
    b = (word[6:0] == opOp) ? shadow[word[24:20]] : {{20{word[31]}}, word[31:20]};
    value = '0;
    bad = 1'b0;
    case (word[6:0])
      opLui: value = {word[31:12], 12'b0};
      opOp, opOpImm: begin
        case (f3)
          3'd0: value = (word[6:0] == opOp && f7 == 7'h20) ? a - b : a + b;
          3'd1: value = a << b[4:0];
          3'd2: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd3: value = (a < b) ? 32'd1 : 32'd0;
          3'd4: value = a ^ b;
          3'd5: begin
            if (f7 == 7'h20) begin
              value = $signed(a) >>> b[4:0];
            end else begin
              value = a >> b[4:0];
            end
          end
          3'd6: value = a | b;
          default: value = a & b;
        endcase
        if (word[6:0] == opOp) begin
          bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
          bad = !(f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd5)); // Shift immediates only
        end
      end
      default: bad = 1'b1;
    endcase
    res.valid = 1'b1;
    res.illegal = bad;
    res.rd = rd;
    res.data = bad ? 32'h0 : value;
    if (!bad && rd != 5'd0) begin
      shadow[rd] = value;
    end
  endtask

  task automatic issue(input logic [31:0] word);
    wbT res;
    expectT e;
    applyModel(word, res);
    e.wb = res;
    e.cycle = cycles + 3;
    expQ.push_back(e);
    instr = word;
    instrValid = 1'b1;
    @(posedge clk);
    #1;
    instrValid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drain();
    while (expQ.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic checkRegs();
    for (int i = 0; i < 32; i++) begin
      dbgAddr = 5'(i);
      @(negedge clk);
      checkValue($sformatf("dbgData[x%0d]", i), dbgData, shadow[i]);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800; // ADDI sign-extends its low 12 bits
    issue(luiWord(rd, upper[31:12]));
    issue(iTypeWord(f3AddSub, rd, rd, value[11:0]));
  endtask

  always @(negedge clk) begin
    expectT e;
    if (reset) begin
      if (cycles > 0) begin // The clock leaves its unknown level before the first edge
        checkValue("retire.valid", retire.valid, 32'h0);
      end
    end else if (retire.valid) begin
      if (expQ.size() == 0) begin
        reportFailure("a retire arrived with no instruction in flight");
      end else begin
        e = expQ.pop_front();
        checkValue("retire cycle", cycles, e.cycle);
        checkValue("retire.illegal", retire.illegal, e.wb.illegal);
        checkValue("retire.rd", retire.rd, e.wb.rd);
        checkValue("retire.data", retire.data, e.wb.data);
      end
    end else if (expQ.size() != 0 && expQ[0].cycle == cycles) begin
      reportFailure($sformatf("no retire in cycle %0d where one was due", cycles));
    end
  end

  task automatic clearRegisters();
    for (int i = 1; i < 32; i++) begin
      issue(iTypeWord(f3AddSub, 5'(i), 5'd0, 12'h000));
    end
    drain();
  endtask

  task automatic testImmediates();
    issue(iTypeWord(f3AddSub, 5'd1, 5'd0, 12'hffb));
    idle(4);
    issue(iTypeWord(f3Xor, 5'd2, 5'd1, 12'h0f0));
    idle(4);
    issue(iTypeWord(f3Or, 5'd3, 5'd1, 12'h700));
    idle(4);
    issue(iTypeWord(f3And, 5'd4, 5'd2, 12'h0ff));
    idle(4);
    issue(iTypeWord(f3Slt, 5'd5, 5'd1, 12'hffc));
    idle(4);
    issue(iTypeWord(f3Slt, 5'd6, 5'd1, 12'hffa));
    idle(4);
    issue(iTypeWord(f3Sltu, 5'd7, 5'd1, 12'h001));
    idle(4);
    issue(luiWord(5'd8, 20'hdeadb));
    idle(4);
    drain();
    checkRegs();
  endtask

  task automatic testRegReg();
    logic [31:0] neg1;
    logic [31:0] neg2;
    logic [31:0] pos;
    logic [4:0] sh;
    neg1 = $urandom() | 32'h8000_0000;
    neg2 = $urandom() | 32'h8000_0000;
    pos = $urandom() & 32'h7fff_ffff;
    sh = 5'($urandom_range(1, 31));
    loadConst(5'd10, neg1);
    loadConst(5'd11, pos);
    loadConst(5'd12, neg2);
    issue(rTypeWord(f7Base, f3AddSub, 5'd13, 5'd10, 5'd11));
    issue(rTypeWord(f7Alt, f3AddSub, 5'd14, 5'd10, 5'd11));
    issue(rTypeWord(f7Base, f3Sll, 5'd15, 5'd10, 5'd11));
    issue(rTypeWord(f7Base, f3SrlSra, 5'd16, 5'd10, 5'd11));
    issue(rTypeWord(f7Alt, f3SrlSra, 5'd17, 5'd10, 5'd11));
    issue(rTypeWord(f7Base, f3Slt, 5'd18, 5'd10, 5'd11)); // Negative against positive
    issue(rTypeWord(f7Base, f3Sltu, 5'd19, 5'd10, 5'd11));
    issue(rTypeWord(f7Base, f3Slt, 5'd20, 5'd10, 5'd12));
    issue(rTypeWord(f7Base, f3Sltu, 5'd21, 5'd12, 5'd10));
    issue(rTypeWord(f7Base, f3Xor, 5'd22, 5'd10, 5'd12));
    issue(rTypeWord(f7Base, f3Or, 5'd23, 5'd11, 5'd12));
    issue(rTypeWord(f7Base, f3And, 5'd24, 5'd10, 5'd12));
    issue(iTypeWord(f3Sll, 5'd25, 5'd10, {7'b0, sh}));
    issue(iTypeWord(f3SrlSra, 5'd26, 5'd10, {7'b0, sh}));
    issue(iTypeWord(f3SrlSra, 5'd27, 5'd10, {f7Alt, sh}));
    drain();
    checkRegs();
  endtask

  task automatic testBackToBack();
    issue(iTypeWord(f3AddSub, 5'd1, 5'd0, 12'h007));
    issue(iTypeWord(f3AddSub, 5'd1, 5'd1, 12'hff0)); // Distance 1 on rs1
    issue(rTypeWord(f7Base, f3AddSub, 5'd2, 5'd0, 5'd1)); // Distance 1 on rs2
    issue(iTypeWord(f3Xor, 5'd3, 5'd1, 12'h05a)); // Distance 2
    issue(rTypeWord(f7Alt, f3AddSub, 5'd4, 5'd2, 5'd1)); // Distances 2 and 3
    issue(rTypeWord(f7Base, f3Sll, 5'd5, 5'd4, 5'd3));
    issue(rTypeWord(f7Base, f3Or, 5'd6, 5'd3, 5'd5)); // Distances 3 and 1
    issue(luiWord(5'd7, 20'h12345));
    issue(rTypeWord(f7Base, f3AddSub, 5'd7, 5'd7, 5'd7));
    issue(rTypeWord(f7Base, f3Xor, 5'd8, 5'd6, 5'd7));
    drain();
    checkRegs();
  endtask

  task automatic testZeroRegister();
    issue(iTypeWord(f3AddSub, 5'd0, 5'd0, 12'h055)); // Retires with rd 0 and is dropped
    issue(rTypeWord(f7Base, f3Or, 5'd9, 5'd0, 5'd0));
    issue(iTypeWord(f3AddSub, 5'd10, 5'd0, 12'h001));
    drain();
    checkRegs();
  endtask

  task automatic testIllegal();
    issue(32'h0000_2083); // LW x1, 0(x0)
    issue(rTypeWord(7'b0000001, f3AddSub, 5'd2, 5'd1, 5'd1)); // MUL
    issue(iTypeWord(f3Sll, 5'd3, 5'd1, 12'h401));
    issue(32'h0000_0063); // BEQ x0, x0, 0
    drain();
    checkRegs();
  endtask

  task automatic testStream();
    logic [31:0] word;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] sh;
    int kind;
    for (int n = 0; n < streamLen; n++) begin
      f3 = 3'($urandom_range(0, 7));
      rd = 5'($urandom_range(0, 7)); // A small window keeps hazards frequent
      rs1 = 5'($urandom_range(0, 7));
      rs2 = 5'($urandom_range(0, 7));
      sh = 5'($urandom());
      f7 = ((f3 == f3AddSub || f3 == f3SrlSra) && $urandom_range(0, 1) == 1) ? f7Alt : f7Base;
      kind = $urandom_range(0, 2);
      if (kind == 0) begin
        word = rTypeWord(f7, f3, rd, rs1, rs2);
      end else if (kind == 1 && (f3 == f3Sll || f3 == f3SrlSra)) begin
        word = iTypeWord(f3, rd, rs1, {(f3 == f3SrlSra) ? f7 : f7Base, sh});
      end else if (kind == 1) begin
        word = iTypeWord(f3, rd, rs1, 12'($urandom()));
      end else begin
        word = luiWord(rd, 20'($urandom()));
      end
      issue(word);
    end
    drain();
    checkRegs();
  endtask

  initial begin
    void'($urandom(82907));
    reset = 1'b1;
    instrValid = 1'b0;
    instr = '0;
    dbgAddr = '0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = 32'h0;
    end
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    clearRegisters(); // The register storage has no reset
    testImmediates();
    testRegReg();
    testBackToBack();
    testZeroRegister();
    testIllegal();
    testStream();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: tb/aluPipe_asserts.sv
module aluPipeAsserts (
  input logic clk,
  input logic reset,
  input logic instrValid,
  input rvPkg::wbT retire
);

  retireAfterThree: assert property (
    @(posedge clk) disable iff (reset) instrValid |-> ##3 retire.valid
  ) else $error("retire.valid missing three cycles after instrValid");

  // Every retire must trace back to an issue slot
  noRetireWithoutIssue: assert property (
    @(posedge clk) disable iff (reset) retire.valid |-> $past(instrValid, 3)
  ) else $error("retire.valid without an instruction issued three cycles earlier");

  illegalCarriesNoData: assert property (
    @(posedge clk) disable iff (reset)
      (retire.valid && retire.illegal) |-> (retire.data == '0)
  ) else $error("illegal retire carries nonzero data");

  quietInReset: assert property (
    @(posedge clk) (reset ##1 reset) |-> !retire.valid
  ) else $error("retire.valid raised while reset is held");

endmodule
